/* chunk_output.sv */
`timescale 1ns/1ps

module chunk_output (
        input  logic              clk_i,
        input  logic              arst_n_i,
        input  logic              window_valid_i,
        input  logic              line_active_i,
        input  pixel_pkg::chunk_t chunk_i,
        output logic              pixel_valid_o,
        output pixel_pkg::chunk_t pixels_o,
        output logic              raw_line_o
);

        always_ff @(posedge clk_i or negedge arst_n_i)
        begin
                if (!arst_n_i)
                begin
                        pixel_valid_o <= 1'b0;
                end
                else
                begin
                        pixel_valid_o <= window_valid_i;  // one pulse per window
                end
        end

        always_ff @(posedge clk_i)
        begin
                if (window_valid_i)
                begin
                        pixels_o <= chunk_i;  // held until the next chunk
                end
        end

        // the line stays up until both pending stages have drained
        assign raw_line_o = line_active_i | window_valid_i | pixel_valid_o;

        // the gearbox needs at least two words per chunk, so pulses never touch
        a_no_back_to_back: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                pixel_valid_o |=> !pixel_valid_o)
                else $error("chunk valid high on two consecutive cycles");

endmodule

/* csi_pkg.sv */
package csi_pkg;

        // lanes of the link, one byte per lane and cycle
        localparam int LANES     = 4;
        localparam int LANE_BITS = 8;
        localparam int WORD_BITS = LANES * LANE_BITS;  // word from the packet decoder

        // data type field of the long packet header, 6 bits wide
        typedef enum logic [5:0] {
                DT_RAW10 = 6'h2B,  // four pixels in five bytes
                DT_RAW12 = 6'h2C   // two pixels in three bytes
        } data_type_t;

        // one beat of packed payload, byte 0 in the low bits is first on the wire
        typedef struct packed {
                logic                 valid;  // high for every cycle of a line
                logic [WORD_BITS-1:0] data;
        } csi_word_t;

endpackage

/* pixel_pkg.sv */
package pixel_pkg;

        localparam int BYTE_BITS        = csi_pkg::LANE_BITS;
        localparam int PIXEL_BITS       = 16;
        localparam int PIXELS_PER_CHUNK = 8;

        // packing groups of the supported RAW formats
        localparam int RAW10_BITS         = 10;
        localparam int RAW10_GROUP_BYTES  = 5;
        localparam int RAW10_GROUP_PIXELS = 4;
        localparam int RAW12_BITS         = 12;
        localparam int RAW12_GROUP_BYTES  = 3;
        localparam int RAW12_GROUP_PIXELS = 2;

        // bytes consumed by one chunk of eight pixels
        localparam int RAW10_CHUNK_BYTES =
                RAW10_GROUP_BYTES * PIXELS_PER_CHUNK / RAW10_GROUP_PIXELS;
        localparam int RAW12_CHUNK_BYTES =
                RAW12_GROUP_BYTES * PIXELS_PER_CHUNK / RAW12_GROUP_PIXELS;

        localparam int WINDOW_BYTES = 12;  // largest chunk, which is RAW12
        localparam int BUF_BYTES    = 15;  // up to 11 leftover bytes plus one word

        typedef enum logic [1:0] {
                FMT_NONE,   // any data type that is not unpacked
                FMT_RAW10,
                FMT_RAW12
        } raw_format_t;

        typedef enum logic [0:0] {
                LINE_IDLE,
                LINE_ACTIVE
        } line_state_t;

        typedef logic [BUF_BYTES-1:0][BYTE_BITS-1:0] byte_buf_t;

        // bytes of one chunk, index 0 is the oldest byte
        typedef struct packed {
                logic                                  valid;
                raw_format_t                           format;
                logic                                  line_active;
                logic [WINDOW_BYTES-1:0][BYTE_BITS-1:0] bytes;
        } byte_window_t;

        typedef logic [PIXELS_PER_CHUNK-1:0][PIXEL_BITS-1:0] chunk_t;  // slot 0 in low bits

endpackage

/* pixel_unpacker.sv */
`timescale 1ns/1ps

module pixel_unpacker #(
        parameter int SLOT = 0  // pixel position inside the chunk, 0 to 7
) (
        input  pixel_pkg::byte_window_t        window_i,
        output logic [pixel_pkg::PIXEL_BITS-1:0] pixel_o
);

        logic [pixel_pkg::BYTE_BITS-1:0] msb10;
        logic [pixel_pkg::BYTE_BITS-1:0] lsb10;
        logic [pixel_pkg::BYTE_BITS-1:0] msb12;
        logic [pixel_pkg::BYTE_BITS-1:0] lsb12;

        always_comb
        begin
                // RAW10 group of five bytes, the fifth one holds four pairs of low bits
                msb10 = window_i.bytes[pixel_pkg::RAW10_GROUP_BYTES *
                                       (SLOT / pixel_pkg::RAW10_GROUP_PIXELS) +
                                       SLOT % pixel_pkg::RAW10_GROUP_PIXELS];
                lsb10 = window_i.bytes[pixel_pkg::RAW10_GROUP_BYTES *
                                       (SLOT / pixel_pkg::RAW10_GROUP_PIXELS) +
                                       pixel_pkg::RAW10_GROUP_PIXELS];

                // RAW12 group of three bytes, the third one holds two low nibbles
                msb12 = window_i.bytes[pixel_pkg::RAW12_GROUP_BYTES *
                                       (SLOT / pixel_pkg::RAW12_GROUP_PIXELS) +
                                       SLOT % pixel_pkg::RAW12_GROUP_PIXELS];
                lsb12 = window_i.bytes[pixel_pkg::RAW12_GROUP_BYTES *
                                       (SLOT / pixel_pkg::RAW12_GROUP_PIXELS) +
                                       pixel_pkg::RAW12_GROUP_PIXELS];

                case (window_i.format)
                        pixel_pkg::FMT_RAW10:
                        begin
                                pixel_o = {msb10,
                                           lsb10[2 * (SLOT % pixel_pkg::RAW10_GROUP_PIXELS) +: 2],
                                           {(pixel_pkg::PIXEL_BITS - pixel_pkg::RAW10_BITS){1'b0}}};
                        end
                        pixel_pkg::FMT_RAW12:
                        begin
                                pixel_o = {msb12,
                                           lsb12[4 * (SLOT % pixel_pkg::RAW12_GROUP_PIXELS) +: 4],
                                           {(pixel_pkg::PIXEL_BITS - pixel_pkg::RAW12_BITS){1'b0}}};
                        end
                        default:
                        begin
                                pixel_o = '0;  // other data types never form a chunk
                        end
                endcase
        end

endmodule

/* raw_depacker_top.sv */
`timescale 1ns/1ps

module raw_depacker_top (
        input  logic                clk_i,
        input  logic                arst_n_i,
        input  csi_pkg::csi_word_t  csi_word_i,
        input  csi_pkg::data_type_t data_type_i,
        output logic                pixel_valid_o,
        output pixel_pkg::chunk_t   pixels_o,
        output logic                raw_line_o
);

        pixel_pkg::byte_window_t window;      // registered bytes of one chunk
        pixel_pkg::chunk_t       chunk_next;  // unpacked pixels of that window

        raw_gearbox u_gearbox (
                .clk_i       (clk_i),
                .arst_n_i    (arst_n_i),
                .csi_word_i  (csi_word_i),
                .data_type_i (data_type_i),
                .window_o    (window)
        );

        // one unpacker per pixel slot, all reading the same window
        generate
                for (genvar s = 0; s < pixel_pkg::PIXELS_PER_CHUNK; s++)
                begin : g_slot
                        pixel_unpacker #(
                                .SLOT (s)
                        ) u_unpacker (
                                .window_i (window),
                                .pixel_o  (chunk_next[s])
                        );
                end
        endgenerate

        chunk_output u_output (
                .clk_i          (clk_i),
                .arst_n_i       (arst_n_i),
                .window_valid_i (window.valid),
                .line_active_i  (window.line_active),
                .chunk_i        (chunk_next),
                .pixel_valid_o  (pixel_valid_o),
                .pixels_o       (pixels_o),
                .raw_line_o     (raw_line_o)
        );

endmodule

/* raw_gearbox.sv */
`timescale 1ns/1ps

module raw_gearbox (
        input  logic                    clk_i,
        input  logic                    arst_n_i,
        input  csi_pkg::csi_word_t      csi_word_i,
        input  csi_pkg::data_type_t     data_type_i,
        output pixel_pkg::byte_window_t window_o
);

        pixel_pkg::line_state_t state_q;
        pixel_pkg::raw_format_t fmt_q;
        pixel_pkg::raw_format_t line_fmt;
        pixel_pkg::byte_buf_t   buf_q;
        pixel_pkg::byte_buf_t   base_buf;
        pixel_pkg::byte_buf_t   fill_buf;
        logic [3:0]             count_q;  // valid bytes in buf_q, from index 0
        logic [4:0]             base_cnt;
        logic [4:0]             fill_cnt;
        logic [4:0]             chunk_len;
        logic                   chunk_done;
        logic                   win_valid_q;
        logic [pixel_pkg::WINDOW_BYTES-1:0][pixel_pkg::BYTE_BITS-1:0] win_bytes_q;

        function automatic pixel_pkg::raw_format_t fmt_of(input csi_pkg::data_type_t dt);
                case (dt)
                        csi_pkg::DT_RAW10: return pixel_pkg::FMT_RAW10;
                        csi_pkg::DT_RAW12: return pixel_pkg::FMT_RAW12;
                        default:           return pixel_pkg::FMT_NONE;
                endcase
        endfunction

        function automatic logic [4:0] chunk_len_of(input pixel_pkg::raw_format_t fmt);
                case (fmt)
                        pixel_pkg::FMT_RAW10: return 5'(pixel_pkg::RAW10_CHUNK_BYTES);
                        pixel_pkg::FMT_RAW12: return 5'(pixel_pkg::RAW12_CHUNK_BYTES);
                        default:              return 5'(pixel_pkg::WINDOW_BYTES);
                endcase
        endfunction

        // a word seen in idle opens a new line with an empty buffer
        always_comb
        begin
                if (state_q == pixel_pkg::LINE_IDLE)
                begin
                        line_fmt = fmt_of(data_type_i);
                        base_buf = '0;
                        base_cnt = '0;
                end
                else
                begin
                        line_fmt = fmt_q;
                        base_buf = buf_q;
                        base_cnt = 5'(count_q);
                end

                chunk_len = chunk_len_of(line_fmt);

                if (line_fmt == pixel_pkg::FMT_NONE)
                begin
                        fill_buf = base_buf;  // nothing to unpack, so nothing is kept
                        fill_cnt = base_cnt;
                end
                else
                begin
                        // bytes above the count are always zero, so an or appends the word
                        fill_buf = base_buf | (pixel_pkg::byte_buf_t'(csi_word_i.data)
                                               << (base_cnt * pixel_pkg::BYTE_BITS));
                        fill_cnt = base_cnt + 5'(csi_pkg::LANES);
                end

                chunk_done = (line_fmt != pixel_pkg::FMT_NONE) && (fill_cnt >= chunk_len);
        end

        always_ff @(posedge clk_i or negedge arst_n_i)
        begin
                if (!arst_n_i)
                begin
                        state_q     <= pixel_pkg::LINE_IDLE;
                        fmt_q       <= pixel_pkg::FMT_NONE;
                        count_q     <= '0;
                        win_valid_q <= 1'b0;
                end
                else if (csi_word_i.valid)
                begin
                        state_q     <= pixel_pkg::LINE_ACTIVE;
                        fmt_q       <= line_fmt;
                        count_q     <= chunk_done ? 4'(fill_cnt - chunk_len) : 4'(fill_cnt);
                        win_valid_q <= chunk_done;
                end
                else
                begin
                        state_q     <= pixel_pkg::LINE_IDLE;  // leftover bytes are dropped here
                        count_q     <= '0;
                        win_valid_q <= 1'b0;
                end
        end

        always_ff @(posedge clk_i)
        begin
                if (csi_word_i.valid)
                begin
                        // shifting out a chunk zero fills the top of the buffer
                        buf_q <= chunk_done ? (fill_buf >> (chunk_len * pixel_pkg::BYTE_BITS))
                                            : fill_buf;
                end
                if (chunk_done)
                begin
                        win_bytes_q <= fill_buf[pixel_pkg::WINDOW_BYTES-1:0];
                end
        end

        assign window_o = '{valid:       win_valid_q,
                            format:      fmt_q,
                            line_active: state_q == pixel_pkg::LINE_ACTIVE,
                            bytes:       win_bytes_q};

        // leftover plus a new word must fit the buffer
        a_fill_fits: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                csi_word_i.valid |-> fill_cnt <= 5'(pixel_pkg::BUF_BYTES))
                else $error("gearbox byte count %0d exceeds buffer", fill_cnt);

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the depacker testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_raw_depacker \
        -f sources.f -o tb_raw_depacker

# the simulation may exit non-zero on a fatal check, the log decides
./obj_dir/tb_raw_depacker > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
        echo "simulation reported a failure"
        exit 1
fi

echo "simulation finished without failure"
exit 0

/* sources.f */
csi_pkg.sv
pixel_pkg.sv
raw_gearbox.sv
pixel_unpacker.sv
chunk_output.sv
raw_depacker_top.sv
tb_raw_depacker.sv

/* tb_raw_depacker.sv */
`timescale 1ns/1ps

module tb_raw_depacker;

        localparam int CLK_PERIOD   = 4;
        localparam int RESET_CYCLES = 5;
        localparam int IDLE_CYCLES  = 4;
        localparam int NUM_LINES    = 5;
        localparam int TOTAL_WORDS  = 20 + 15 + 7 + 6 + 6;
        localparam int TIMEOUT_NS   = (TOTAL_WORDS + NUM_LINES * (IDLE_CYCLES + 1) +
                                       2 * RESET_CYCLES + 20) * CLK_PERIOD;

        logic                clk = 1'b0;
        logic                arst_n;
        csi_pkg::csi_word_t  csi_word;
        csi_pkg::data_type_t data_type;
        logic                pixel_valid;
        pixel_pkg::chunk_t   pixels;
        logic                raw_line;

        logic                chunk_due;    // the word driven now completes a chunk
        logic                due_q;        // model of the window register
        logic                exp_valid_q;  // model of the output register
        logic                line_q;       // model of the line state
        pixel_pkg::chunk_t   exp_chunk_q;
        pixel_pkg::chunk_t   expected_q[$];
        logic [7:0]          byte_q[$];
        integer              seed = 53581;
        string               test_name = "reset";

        raw_depacker_top UUT (
                .clk_i         (clk),
                .arst_n_i      (arst_n),
                .csi_word_i    (csi_word),
                .data_type_i   (data_type),
                .pixel_valid_o (pixel_valid),
                .pixels_o      (pixels),
                .raw_line_o    (raw_line)
        );

        always #(CLK_PERIOD / 2) clk = ~clk;

        // expected output follows the completing word by one edge for the window
        // and by one more edge for the output register
        always @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        due_q       <= 1'b0;
                        exp_valid_q <= 1'b0;
                        line_q      <= 1'b0;
                end
                else
                begin
                        line_q      <= csi_word.valid;
                        due_q       <= chunk_due;
                        exp_valid_q <= due_q;
                        if (due_q)
                        begin
                                exp_chunk_q <= expected_q.pop_front();
                        end
                end
        end

        // four pixels of 10 bits in five bytes, low bit pairs in the fifth byte
        task automatic pack_raw10_chunk();
                pixel_pkg::chunk_t chunk;
                logic [31:0]       r;
                logic [9:0]        p;
                logic [7:0]        low;
                for (int g = 0; g < 2; g++)
                begin
                        low = '0;
                        for (int j = 0; j < 4; j++)
                        begin
                                r = $random(seed);
                                p = r[9:0];
                                chunk[4 * g + j] = {p, 6'b0};
                                byte_q.push_back(p[9:2]);
                                low[2 * j +: 2] = p[1:0];
                        end
                        byte_q.push_back(low);
                end
                expected_q.push_back(chunk);
        endtask

        // two pixels of 12 bits in three bytes, low nibbles in the third byte
        task automatic pack_raw12_chunk();
                pixel_pkg::chunk_t chunk;
                logic [31:0]       r;
                logic [11:0]       p0;
                logic [11:0]       p1;
                for (int g = 0; g < 4; g++)
                begin
                        r = $random(seed);
                        p0 = r[11:0];
                        p1 = r[27:16];
                        chunk[2 * g]     = {p0, 4'b0};
                        chunk[2 * g + 1] = {p1, 4'b0};
                        byte_q.push_back(p0[11:4]);
                        byte_q.push_back(p1[11:4]);
                        byte_q.push_back({p1[3:0], p0[3:0]});
                end
                expected_q.push_back(chunk);
        endtask

        // packs whole chunks, pads the line with random bytes and drives it
        task automatic drive_line(input string name, input csi_pkg::data_type_t dt,
                                  input int words);
                int          size;
                int          count;
                int          done;
                logic [31:0] r;
                if (dt == csi_pkg::DT_RAW10)
                begin
                        size = 10;
                end
                else if (dt == csi_pkg::DT_RAW12)
                begin
                        size = 12;
                end
                else
                begin
                        size = 0;  // no chunk is ever complete
                end
                byte_q.delete();
                while (size != 0 && byte_q.size() + size <= 4 * words)
                begin
                        if (size == 10)
                        begin
                                pack_raw10_chunk();
                        end
                        else
                        begin
                                pack_raw12_chunk();
                        end
                end
                while (byte_q.size() < 4 * words)
                begin
                        r = $random(seed);
                        byte_q.push_back(r[7:0]);  // tail bytes that get dropped
                end
                count = 0;
                done  = 0;
                for (int w = 0; w < words; w++)
                begin
                        @(negedge clk);
                        test_name      = name;
                        data_type      = dt;
                        csi_word.valid = 1'b1;
                        csi_word.data  = {byte_q[4 * w + 3], byte_q[4 * w + 2],
                                          byte_q[4 * w + 1], byte_q[4 * w]};
                        count          = count + 4;
                        chunk_due      = (size != 0) && (count >= (done + 1) * size);
                        if (chunk_due)
                        begin
                                done = done + 1;
                        end
                end
                @(negedge clk);
                csi_word  = '0;
                chunk_due = 1'b0;
                repeat (IDLE_CYCLES) @(negedge clk);
        endtask

        a_valid_timing: assert property (@(negedge clk) disable iff (!arst_n)
                pixel_valid == exp_valid_q)
                else
                begin
                        $display("Error: %s pixel_valid expected %0b actual %0b",
                                 test_name, exp_valid_q, pixel_valid);
                        $display("sim failed");
                        $fatal(1);
                end

        a_chunk_data: assert property (@(negedge clk) disable iff (!arst_n)
                exp_valid_q |-> pixels == exp_chunk_q)
                else
                begin
                        $display("Error: %s pixels expected %h actual %h",
                                 test_name, exp_chunk_q, pixels);
                        $display("sim failed");
                        $fatal(1);
                end

        a_line_flag: assert property (@(negedge clk) disable iff (!arst_n)
                raw_line == (line_q | due_q | exp_valid_q))
                else
                begin
                        $display("Error: %s raw_line expected %0b actual %0b",
                                 test_name, line_q | due_q | exp_valid_q, raw_line);
                        $display("sim failed");
                        $fatal(1);
                end

        a_single_pulse: assert property (@(negedge clk) disable iff (!arst_n)
                pixel_valid |=> !pixel_valid)
                else
                begin
                        $display("Error: %s pixel_valid expected 0 actual 1 after a pulse",
                                 test_name);
                        $display("sim failed");
                        $fatal(1);
                end

        initial
        begin
                arst_n    = 1'b0;
                csi_word  = '0;
                data_type = csi_pkg::DT_RAW10;
                chunk_due = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                arst_n    = 1'b1;
                test_name = "idle_after_reset";
                repeat (IDLE_CYCLES) @(negedge clk);

                drive_line("raw10_full", csi_pkg::DT_RAW10, 20);
                drive_line("raw12_full", csi_pkg::DT_RAW12, 15);
                drive_line("raw10_partial", csi_pkg::DT_RAW10, 7);
                drive_line("raw12_after_partial", csi_pkg::DT_RAW12, 6);
                drive_line("unsupported_type", csi_pkg::data_type_t'(6'h2A), 6);

                $display("sim passed");
                $finish;
        end

        initial
        begin
                #(TIMEOUT_NS);
                $display("watchdog expired before the test sequence finished");
                $display("sim failed");
                $fatal(1);
        end

endmodule
